// ==== Makefile ====
# Verilator flow for the ARM pipeline controller

VERILATOR ?= verilator
TOP       ?= armCtrlTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "No result line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/armCtrlPkg.sv ====
`default_nettype none

package armCtrlPkg;

  // Decode classes
  typedef enum logic [2:0] {
    ClsDpImm,
    ClsDpReg,
    ClsLoad,
    ClsStore,
    ClsBranch,
    ClsUndef
  } instrClassT;

  // ALU opcode, same encoding as instr bits 24:21
  typedef enum logic [3:0] {
    OpAnd = 4'h0,
    OpEor = 4'h1,
    OpSub = 4'h2,
    OpRsb = 4'h3,
    OpAdd = 4'h4,
    OpAdc = 4'h5,
    OpSbc = 4'h6,
    OpRsc = 4'h7,
    OpTst = 4'h8,   // Compares, no register write
    OpTeq = 4'h9,
    OpCmp = 4'hA,
    OpCmn = 4'hB,
    OpOrr = 4'hC,
    OpMov = 4'hD,
    OpBic = 4'hE,
    OpMvn = 4'hF
  } aluOpT;

  // Condition field, 4'hF left out and read as never
  typedef enum logic [3:0] {
    CondEq = 4'h0, CondNe = 4'h1, CondCs = 4'h2, CondCc = 4'h3,
    CondMi = 4'h4, CondPl = 4'h5, CondVs = 4'h6, CondVc = 4'h7,
    CondHi = 4'h8, CondLs = 4'h9, CondGe = 4'hA, CondLt = 4'hB,
    CondGt = 4'hC, CondLe = 4'hD, CondAl = 4'hE
  } condT;

endpackage

`default_nettype wire

// ==== common/armCtrl_config.svh ====
`ifndef ARM_CTRL_CONFIG_SVH
`define ARM_CTRL_CONFIG_SVH

// ====================
// Datapath widths
// ====================
`define ARM_INSTR_W  32   // Instruction word
`define ARM_FLAG_W   4    // NZCV
`define ARM_MASK_W   4    // Byte lanes per word

`define ARM_PC_REG   15   // R15 is the PC

// ====================
// Field positions
// ====================
`define ARM_COND_LSB 28   // Cond in 31:28
`define ARM_RD_LSB   12   // Rd in 15:12
`define ARM_OPC_LSB  21   // DP opcode in 24:21

// Single-bit fields
`define ARM_SBIT     20   // Set flags, data processing
`define ARM_UBIT     23   // Up/down, load/store offset
`define ARM_BBIT     22   // Byte/word, load/store
`define ARM_LBIT     20   // Load/store select

`endif

// ==== decode/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "armCtrl_config.svh"

module instrDecoder (
  input  logic [`ARM_INSTR_W-1:0] instrD,
  output armCtrlPkg::instrClassT  cls,
  output armCtrlPkg::aluOpT       aluOpD,
  output logic                    aluSrcD,    // 1 = immediate operand
  output logic                    regWriteD,
  output logic                    memWriteD,
  output logic                    memtoRegD,
  output logic                    branchD,
  output logic                    pcSrcD,
  output logic                    setFlagsD,
  output logic                    logicOpD,   // Keeps C and V
  output logic                    byteD,
  output logic [1:0]              regSrcD,
  output logic [1:0]              immSrcD
);

  import armCtrlPkg::*;

  aluOpT dpOp;
  aluOpT memOp;
  logic  isCompare;
  logic  isLogic;
  logic  rdIsPc;

  assign dpOp      = aluOpT'(instrD[`ARM_OPC_LSB +: 4]);
  assign memOp     = instrD[`ARM_UBIT] ? OpAdd : OpSub;   // Offset up or down
  assign isCompare = dpOp inside {OpTst, OpTeq, OpCmp, OpCmn};
  assign isLogic   = dpOp inside {OpAnd, OpEor, OpTst, OpTeq, OpOrr, OpMov, OpBic, OpMvn};
  assign rdIsPc    = (instrD[`ARM_RD_LSB +: 4] == 4'(`ARM_PC_REG));

  // ====================
  // Classification
  // ====================
  always_comb begin
    case (instrD[27:25])
      3'b000:  cls = instrD[4] ? ClsUndef : ClsDpReg;       // Reg-shifted forms dropped
      3'b001:  cls = ClsDpImm;
      3'b010:  cls = instrD[`ARM_LBIT] ? ClsLoad : ClsStore; // Immediate offset
      3'b011: begin
        if (instrD[4])
          cls = ClsUndef;                                    // Media space
        else
          cls = instrD[`ARM_LBIT] ? ClsLoad : ClsStore;      // Register offset
      end
      3'b101:  cls = ClsBranch;
      default: cls = ClsUndef;
    endcase
  end

  // ====================
  // Control bits
  // ====================
  always_comb begin
    aluOpD    = OpAnd;    // All zero unless a class claims it
    aluSrcD   = 1'b0;
    regWriteD = 1'b0;
    memWriteD = 1'b0;
    memtoRegD = 1'b0;
    branchD   = 1'b0;
    setFlagsD = 1'b0;
    logicOpD  = 1'b0;
    byteD     = 1'b0;
    regSrcD   = 2'b00;
    immSrcD   = 2'b00;
    case (cls)
      ClsDpImm, ClsDpReg: begin
        aluOpD    = dpOp;
        aluSrcD   = (cls == ClsDpImm);
        regWriteD = !isCompare;            // TST/TEQ/CMP/CMN only touch flags
        setFlagsD = instrD[`ARM_SBIT];
        logicOpD  = isLogic;
      end
      ClsLoad: begin
        aluOpD    = memOp;
        aluSrcD   = !instrD[25];           // I bit clear means 12-bit offset
        regWriteD = 1'b1;
        memtoRegD = 1'b1;
        byteD     = instrD[`ARM_BBIT];
        immSrcD   = 2'b01;
      end
      ClsStore: begin
        aluOpD    = memOp;
        aluSrcD   = !instrD[25];
        memWriteD = 1'b1;
        byteD     = instrD[`ARM_BBIT];
        regSrcD   = 2'b10;                 // Rd read as store data
        immSrcD   = 2'b01;
      end
      ClsBranch: begin
        aluOpD    = OpAdd;                 // PC + offset
        aluSrcD   = 1'b1;
        branchD   = 1'b1;
        regSrcD   = 2'b01;                 // Read PC as Rn
        immSrcD   = 2'b10;                 // 24-bit offset
      end
      default: ;                           // Undefined
    endcase
    pcSrcD = branchD | (regWriteD & rdIsPc);
  end

endmodule

`default_nettype wire

// ==== execute/condCheck.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "armCtrl_config.svh"

module condCheck (
  input  armCtrlPkg::condT       cond,
  input  logic [`ARM_FLAG_W-1:0] flags,      // Forwarded NZCV
  input  logic [`ARM_FLAG_W-1:0] aluFlags,   // Fresh NZCV from ALU
  input  logic                   setFlags,
  input  logic                   logicOp,
  output logic                   condEx,
  output logic [`ARM_FLAG_W-1:0] flagsNext
);

  import armCtrlPkg::*;

  logic n, z, c, v;

  assign {n, z, c, v} = flags;

  // ARM condition table
  always_comb begin
    case (cond)
      CondEq:  condEx = z;
      CondNe:  condEx = !z;
      CondCs:  condEx = c;
      CondCc:  condEx = !c;
      CondMi:  condEx = n;
      CondPl:  condEx = !n;
      CondVs:  condEx = v;
      CondVc:  condEx = !v;
      CondHi:  condEx = c & !z;          // Unsigned higher
      CondLs:  condEx = !c | z;
      CondGe:  condEx = (n == v);         // Signed compares
      CondLt:  condEx = (n != v);
      CondGt:  condEx = !z & (n == v);
      CondLe:  condEx = z | (n != v);
      CondAl:  condEx = 1'b1;
      default: condEx = 1'b0;             // 4'hF never
    endcase
  end

  // N and Z always from the ALU when flags are set
  assign flagsNext = !setFlags ? flags :
                     logicOp   ? {aluFlags[3:2], flags[1:0]} : aluFlags;

endmodule

`default_nettype wire

// ==== execute/execStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "armCtrl_config.svh"

module execStage (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    stall,
  input  logic                    flushE,
  // Decode controls
  input  armCtrlPkg::instrClassT  clsD,
  input  armCtrlPkg::aluOpT       aluOpD,
  input  logic                    aluSrcD,
  input  logic                    regWriteD,
  input  logic                    memWriteD,
  input  logic                    memtoRegD,
  input  logic                    branchD,
  input  logic                    pcSrcD,
  input  logic                    setFlagsD,
  input  logic                    logicOpD,
  input  logic                    byteD,
  input  logic [3:0]              condD,      // Raw cond field
  // Datapath and forwarding
  input  logic [`ARM_FLAG_W-1:0]  aluFlagsE,
  input  logic [1:0]              byteAddrE,
  input  logic [`ARM_FLAG_W-1:0]  flagsE,
  // Execute outputs
  output armCtrlPkg::aluOpT       aluOpE,
  output logic                    aluSrcE,
  output logic                    branchTakenE,
  output logic                    memWriteGE,
  output logic                    memtoRegGE,
  output logic                    regWriteGE,
  output logic                    pcSrcGE,
  output logic                    setFlagsGE,
  output logic [`ARM_FLAG_W-1:0]  flagsNextE,
  output logic [`ARM_MASK_W-1:0]  byteMaskE
);

  import armCtrlPkg::*;

  instrClassT clsE;
  condT       condE;
  logic       regWriteE, memWriteE, memtoRegE;
  logic       branchE, pcSrcE, setFlagsE, logicOpE, byteE;
  logic       condEx;

  // ====================
  // D to E register
  // ====================
  always_ff @(posedge clk) begin
    if (!rstN || (flushE && !stall)) begin   // Bubble
      clsE      <= ClsDpImm;
      aluOpE    <= OpAnd;
      condE     <= CondEq;
      aluSrcE   <= 1'b0;
      regWriteE <= 1'b0;
      memWriteE <= 1'b0;
      memtoRegE <= 1'b0;
      branchE   <= 1'b0;
      pcSrcE    <= 1'b0;
      setFlagsE <= 1'b0;
      logicOpE  <= 1'b0;
      byteE     <= 1'b0;
    end else if (!stall) begin
      clsE      <= clsD;
      aluOpE    <= aluOpD;
      condE     <= condT'(condD);   // 4'hF kept, checks as never
      aluSrcE   <= aluSrcD;
      regWriteE <= regWriteD;
      memWriteE <= memWriteD;
      memtoRegE <= memtoRegD;
      branchE   <= branchD;
      pcSrcE    <= pcSrcD;
      setFlagsE <= setFlagsD;
      logicOpE  <= logicOpD;
      byteE     <= byteD;
    end
  end

  condCheck uCondCheck (
    .cond      (condE),
    .flags     (flagsE),
    .aluFlags  (aluFlagsE),
    .setFlags  (setFlagsE),
    .logicOp   (logicOpE),
    .condEx    (condEx),
    .flagsNext (flagsNextE)
  );

  // Side effects only when condition passes
  assign branchTakenE = branchE   & condEx;
  assign memWriteGE   = memWriteE & condEx;
  assign memtoRegGE   = memtoRegE & condEx;   // No stray loads
  assign regWriteGE   = regWriteE & condEx;
  assign pcSrcGE      = pcSrcE    & condEx;
  assign setFlagsGE   = setFlagsE & condEx;

  // Store lanes
  always_comb begin
    byteMaskE = '0;
    if (clsE == ClsStore) begin
      if (byteE)
        byteMaskE[byteAddrE] = 1'b1;   // One lane from address LSBs
      else
        byteMaskE = '1;                // Whole word
    end
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+common
common/armCtrlPkg.sv
decode/instrDecoder.sv
execute/condCheck.sv
execute/execStage.sv
rtl/retireStage.sv
rtl/armCtrlTop.sv
sim/armCtrl_assert.sv
sim/armCtrlTb.sv

// ==== rtl/armCtrlTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "armCtrl_config.svh"

module armCtrlTop (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [`ARM_INSTR_W-1:0] instrD,
  input  logic                    stall,      // Freezes every stage
  input  logic                    flushE,     // Bubble into Execute
  input  logic [`ARM_FLAG_W-1:0]  aluFlagsE,
  input  logic [1:0]              byteAddrE,
  output logic [1:0]              regSrcD,
  output logic [1:0]              immSrcD,
  output armCtrlPkg::aluOpT       aluOpE,
  output logic                    aluSrcE,
  output logic                    branchTakenE,
  output logic [`ARM_FLAG_W-1:0]  flagsE,
  output logic                    memWriteM,
  output logic                    memtoRegM,
  output logic                    regWriteM,
  output logic [`ARM_MASK_W-1:0]  byteMaskM,
  output logic                    regWriteW,
  output logic                    memtoRegW,
  output logic                    pcSrcW,
  output logic [`ARM_FLAG_W-1:0]  cpsrFlags
);

  import armCtrlPkg::*;

  // Decode controls
  instrClassT clsD;
  aluOpT      aluOpD;
  logic       aluSrcD, regWriteD, memWriteD, memtoRegD;
  logic       branchD, pcSrcD, setFlagsD, logicOpD, byteD;

  // Gated Execute results
  logic                   memWriteGE, memtoRegGE, regWriteGE, pcSrcGE, setFlagsGE;
  logic [`ARM_FLAG_W-1:0] flagsNextE;
  logic [`ARM_MASK_W-1:0] byteMaskE;

  instrDecoder uDecoder (
    .instrD    (instrD),
    .cls       (clsD),
    .aluOpD    (aluOpD),
    .aluSrcD   (aluSrcD),
    .regWriteD (regWriteD),
    .memWriteD (memWriteD),
    .memtoRegD (memtoRegD),
    .branchD   (branchD),
    .pcSrcD    (pcSrcD),
    .setFlagsD (setFlagsD),
    .logicOpD  (logicOpD),
    .byteD     (byteD),
    .regSrcD   (regSrcD),
    .immSrcD   (immSrcD)
  );

  execStage uExec (
    .clk          (clk),
    .rstN         (rstN),
    .stall        (stall),
    .flushE       (flushE),
    .clsD         (clsD),
    .aluOpD       (aluOpD),
    .aluSrcD      (aluSrcD),
    .regWriteD    (regWriteD),
    .memWriteD    (memWriteD),
    .memtoRegD    (memtoRegD),
    .branchD      (branchD),
    .pcSrcD       (pcSrcD),
    .setFlagsD    (setFlagsD),
    .logicOpD     (logicOpD),
    .byteD        (byteD),
    .condD        (instrD[`ARM_INSTR_W-1:`ARM_COND_LSB]),
    .aluFlagsE    (aluFlagsE),
    .byteAddrE    (byteAddrE),
    .flagsE       (flagsE),
    .aluOpE       (aluOpE),
    .aluSrcE      (aluSrcE),
    .branchTakenE (branchTakenE),
    .memWriteGE   (memWriteGE),
    .memtoRegGE   (memtoRegGE),
    .regWriteGE   (regWriteGE),
    .pcSrcGE      (pcSrcGE),
    .setFlagsGE   (setFlagsGE),
    .flagsNextE   (flagsNextE),
    .byteMaskE    (byteMaskE)
  );

  retireStage uRetire (
    .clk        (clk),
    .rstN       (rstN),
    .stall      (stall),
    .memWriteGE (memWriteGE),
    .memtoRegGE (memtoRegGE),
    .regWriteGE (regWriteGE),
    .pcSrcGE    (pcSrcGE),
    .setFlagsGE (setFlagsGE),
    .flagsNextE (flagsNextE),
    .byteMaskE  (byteMaskE),
    .memWriteM  (memWriteM),
    .memtoRegM  (memtoRegM),
    .regWriteM  (regWriteM),
    .byteMaskM  (byteMaskM),
    .regWriteW  (regWriteW),
    .memtoRegW  (memtoRegW),
    .pcSrcW     (pcSrcW),
    .flagsE     (flagsE),
    .cpsrFlags  (cpsrFlags)
  );

endmodule

`default_nettype wire

// ==== rtl/retireStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "armCtrl_config.svh"

module retireStage (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   stall,
  // Gated Execute results
  input  logic                   memWriteGE,
  input  logic                   memtoRegGE,
  input  logic                   regWriteGE,
  input  logic                   pcSrcGE,
  input  logic                   setFlagsGE,
  input  logic [`ARM_FLAG_W-1:0] flagsNextE,
  input  logic [`ARM_MASK_W-1:0] byteMaskE,
  // Memory
  output logic                   memWriteM,
  output logic                   memtoRegM,
  output logic                   regWriteM,
  output logic [`ARM_MASK_W-1:0] byteMaskM,
  // Writeback
  output logic                   regWriteW,
  output logic                   memtoRegW,
  output logic                   pcSrcW,
  // Flags
  output logic [`ARM_FLAG_W-1:0] flagsE,      // To condition check
  output logic [`ARM_FLAG_W-1:0] cpsrFlags
);

  logic                   pcSrcM, setFlagsM, setFlagsW;
  logic [`ARM_FLAG_W-1:0] flagsNextM, flagsNextW;

  // ====================
  // M, W and NZCV
  // ====================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      memWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      regWriteM <= 1'b0;
      pcSrcM    <= 1'b0;
      setFlagsM <= 1'b0;
      byteMaskM <= '0;
      regWriteW <= 1'b0;
      memtoRegW <= 1'b0;
      pcSrcW    <= 1'b0;
      setFlagsW <= 1'b0;
      cpsrFlags <= '0;
    end else if (!stall) begin
      memWriteM <= memWriteGE;
      memtoRegM <= memtoRegGE;
      regWriteM <= regWriteGE;
      pcSrcM    <= pcSrcGE;
      setFlagsM <= setFlagsGE;
      byteMaskM <= byteMaskE;
      regWriteW <= regWriteM;
      memtoRegW <= memtoRegM;
      pcSrcW    <= pcSrcM;
      setFlagsW <= setFlagsM;
      if (setFlagsW)
        cpsrFlags <= flagsNextW;   // Commit at end of Writeback
    end
  end

  // Flag payload, qualified by setFlags
  always_ff @(posedge clk) begin
    if (!stall) begin
      flagsNextM <= flagsNextE;
      flagsNextW <= flagsNextM;
    end
  end

  // Youngest flag setter wins
  assign flagsE = setFlagsM ? flagsNextM :
                  setFlagsW ? flagsNextW : cpsrFlags;

endmodule

`default_nettype wire

// ==== sim/armCtrlTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module armCtrlTb;

  import armCtrlPkg::*;

  localparam int ClkPeriod   = 100;
  localparam int ResetCycles = 3;
  localparam int IdleLen     = 20;
  localparam int RunLen      = 200;
  localparam int HazardLen   = 300;
  localparam int TotalCycles = IdleLen + 4 * RunLen + HazardLen;
  localparam int WatchdogNs  = (TotalCycles + ResetCycles + 50) * ClkPeriod;   // Plus margin

  // Instruction mixes
  localparam int KindUndef = 0;
  localparam int KindDp    = 1;
  localparam int KindMem   = 2;
  localparam int KindBr    = 3;
  localparam int KindMix   = 4;

  // Model of the Execute stage contents
  typedef struct packed {
    logic [3:0] aluOp;
    logic [3:0] cond;
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       aluSrc, regWrite, memWrite, memtoReg, branch, pcSrc;
    logic       setFlags, logicOp, byteOp, isStore;
  } decT;

  // Model of Memory and Writeback contents
  typedef struct packed {
    logic       memWrite, memtoReg, regWrite, pcSrc, setFlags;
    logic [3:0] flagsNext;
    logic [3:0] byteMask;
  } retT;

  logic        clk, rstN, stall, flushE;
  logic [31:0] instrD;
  logic [3:0]  aluFlagsE;
  logic [1:0]  byteAddrE;
  logic [1:0]  regSrcD, immSrcD;
  aluOpT       aluOpE;
  logic        aluSrcE, branchTakenE, memWriteM, memtoRegM, regWriteM;
  logic        regWriteW, memtoRegW, pcSrcW;
  logic [3:0]  flagsE, byteMaskM, cpsrFlags;

  decT         refE;
  retT         refM, refW;
  logic [3:0]  refCpsr;
  int          errCount, checkCount;
  int unsigned seedVal;

  armCtrlTop dut (
    .clk          (clk),
    .rstN         (rstN),
    .instrD       (instrD),
    .stall        (stall),
    .flushE       (flushE),
    .aluFlagsE    (aluFlagsE),
    .byteAddrE    (byteAddrE),
    .regSrcD      (regSrcD),
    .immSrcD      (immSrcD),
    .aluOpE       (aluOpE),
    .aluSrcE      (aluSrcE),
    .branchTakenE (branchTakenE),
    .flagsE       (flagsE),
    .memWriteM    (memWriteM),
    .memtoRegM    (memtoRegM),
    .regWriteM    (regWriteM),
    .byteMaskM    (byteMaskM),
    .regWriteW    (regWriteW),
    .memtoRegW    (memtoRegW),
    .pcSrcW       (pcSrcW),
    .cpsrFlags    (cpsrFlags)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // ====================
  // Reference rules
  // ====================
  function automatic decT refDecode(input logic [31:0] ins);
    decT        d;
    logic [2:0] op3;
    logic [3:0] opc;
    d    = '0;
    op3  = ins[27:25];
    opc  = ins[24:21];
    d.cond = ins[31:28];
    if ((op3 == 3'b000 && !ins[4]) || op3 == 3'b001) begin   // Data processing
      d.aluOp    = opc;
      d.aluSrc   = ins[25];
      d.regWrite = (opc[3:2] != 2'b10);                       // Not TST..CMN
      d.setFlags = ins[20];
      d.logicOp  = opc inside {4'h0, 4'h1, 4'h8, 4'h9, [4'hC:4'hF]};
    end else if (op3 == 3'b010 || (op3 == 3'b011 && !ins[4])) begin
      d.aluOp  = ins[23] ? OpAdd : OpSub;   // U bit
      d.aluSrc = !ins[25];
      d.byteOp = ins[22];
      d.immSrc = 2'b01;
      if (ins[20]) begin                    // Load
        d.regWrite = 1'b1;
        d.memtoReg = 1'b1;
      end else begin
        d.memWrite = 1'b1;
        d.isStore  = 1'b1;
        d.regSrc   = 2'b10;
      end
    end else if (op3 == 3'b101) begin       // Branch
      d.aluOp  = OpAdd;
      d.aluSrc = 1'b1;
      d.branch = 1'b1;
      d.regSrc = 2'b01;
      d.immSrc = 2'b10;
    end
    d.pcSrc = d.branch | (d.regWrite & (ins[15:12] == 4'hF));
    return d;
  endfunction

  // ARM condition table
  function automatic logic condHolds(input logic [3:0] cond, input logic [3:0] nzcv);
    logic n, z, c, v;
    {n, z, c, v} = nzcv;
    case (cond)
      CondEq:  return z;
      CondNe:  return !z;
      CondCs:  return c;
      CondCc:  return !c;
      CondMi:  return n;
      CondPl:  return !n;
      CondVs:  return v;
      CondVc:  return !v;
      CondHi:  return c && !z;
      CondLs:  return !c || z;
      CondGe:  return n == v;
      CondLt:  return n != v;
      CondGt:  return !z && (n == v);
      CondLe:  return z || (n != v);
      CondAl:  return 1'b1;
      default: return 1'b0;   // 1111 never
    endcase
  endfunction

  function automatic logic [31:0] makeInstr(input int kind, input logic [3:0] cond);
    logic [31:0] r;
    r = $urandom;
    case (kind)
      KindDp: begin
        r[27:26] = 2'b00;
        if (!r[25])
          r[4] = 1'b0;          // Register form needs bit 4 clear
        if ($urandom % 4 == 0)
          r[15:12] = 4'hF;      // Rd = PC now and then
      end
      KindMem: begin
        r[27:26] = 2'b01;
        if (r[25])
          r[4] = 1'b0;
      end
      KindBr:  r[27:25] = 3'b101;
      default: begin
        case ($urandom % 5)     // Undefined corners
          0:       r[27:25] = 3'b100;
          1:       r[27:25] = 3'b110;
          2:       r[27:25] = 3'b111;
          3:       r[27:25] = 3'b000;
          default: r[27:25] = 3'b011;
        endcase
        r[4] = 1'b1;
      end
    endcase
    r[31:28] = cond;
    return r;
  endfunction

  // ====================
  // Checking
  // ====================
  task automatic checkVal(input string name, input logic [3:0] got, input logic [3:0] exp);
    checkCount++;
    assert (got === exp)
      else begin
        errCount++;
        $display("ERROR %0t ns %s expected %0h got %0h", $time, name, exp, got);
      end
  endtask

  // Compare at negedge, then step the model as the next edge will
  task automatic checkAndAdvance();
    logic [3:0] fwd;
    logic       pass;
    decT        dec;
    fwd  = refM.setFlags ? refM.flagsNext : (refW.setFlags ? refW.flagsNext : refCpsr);
    pass = condHolds(refE.cond, fwd);
    dec  = refDecode(instrD);
    checkVal("regSrcD", 4'(regSrcD), 4'(dec.regSrc));
    checkVal("immSrcD", 4'(immSrcD), 4'(dec.immSrc));
    checkVal("aluOpE", 4'(aluOpE), refE.aluOp);
    checkVal("aluSrcE", 4'(aluSrcE), 4'(refE.aluSrc));
    checkVal("branchTakenE", 4'(branchTakenE), 4'(refE.branch & pass));
    checkVal("flagsE", flagsE, fwd);
    checkVal("memWriteM", 4'(memWriteM), 4'(refM.memWrite));
    checkVal("memtoRegM", 4'(memtoRegM), 4'(refM.memtoReg));
    checkVal("regWriteM", 4'(regWriteM), 4'(refM.regWrite));
    checkVal("byteMaskM", byteMaskM, refM.byteMask);
    checkVal("regWriteW", 4'(regWriteW), 4'(refW.regWrite));
    checkVal("memtoRegW", 4'(memtoRegW), 4'(refW.memtoReg));
    checkVal("pcSrcW", 4'(pcSrcW), 4'(refW.pcSrc));
    checkVal("cpsrFlags", cpsrFlags, refCpsr);
    if (!stall) begin
      if (refW.setFlags)
        refCpsr = refW.flagsNext;   // Commit out of Writeback
      refW = refM;
      refM.memWrite  = refE.memWrite & pass;
      refM.memtoReg  = refE.memtoReg & pass;
      refM.regWrite  = refE.regWrite & pass;
      refM.pcSrc     = refE.pcSrc & pass;
      refM.setFlags  = refE.setFlags & pass;
      refM.flagsNext = refE.logicOp ? {aluFlagsE[3:2], fwd[1:0]} : aluFlagsE;
      refM.byteMask  = !refE.isStore ? 4'h0 : (refE.byteOp ? 4'b0001 << byteAddrE : 4'hF);
      refE = flushE ? '0 : dec;     // Flush leaves a bubble
    end
  endtask

  task automatic runTest(input string name, input int kind, input int cycles,
                         input bit anyCond, input bit forceS, input int hazardPct);
    int          errBefore;
    int          k;
    logic [31:0] ins;
    errBefore = errCount;
    for (int i = 0; i < cycles; i++) begin
      k   = (kind == KindMix) ? int'($urandom % 4) : kind;
      ins = makeInstr(k, anyCond ? 4'($urandom) : 4'hE);
      if (forceS && k == KindDp)
        ins[20] = 1'b1;
      #1;
      instrD    = ins;
      stall     = ($urandom % 100) < hazardPct;
      flushE    = ($urandom % 100) < hazardPct;
      aluFlagsE = 4'($urandom);
      byteAddrE = 2'($urandom);
      @(negedge clk);
      checkAndAdvance();
      @(posedge clk);
    end
    $display("%-28s %0d cycles, %0d errors", name, cycles, errCount - errBefore);
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    seedVal    = $urandom(32'h201d_1f5d);
    clk        = 1'b0;
    rstN       = 1'b0;
    stall      = 1'b0;
    flushE     = 1'b0;
    instrD     = 32'hEE00_0000;   // Undefined encoding
    aluFlagsE  = '0;
    byteAddrE  = '0;
    errCount   = 0;
    checkCount = 0;
    refE       = '0;
    refM       = '0;
    refW       = '0;
    refCpsr    = '0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rstN = 1'b1;
    @(posedge clk);

    runTest("reset and undefined", KindUndef, IdleLen, 1'b1, 1'b0, 0);
    runTest("data processing", KindDp, RunLen, 1'b0, 1'b0, 0);
    runTest("conditional execution", KindMix, RunLen, 1'b1, 1'b0, 0);
    runTest("flag update", KindDp, RunLen, 1'b1, 1'b1, 0);
    runTest("loads and stores", KindMem, RunLen, 1'b0, 1'b0, 0);
    runTest("stall and flush", KindMix, HazardLen, 1'b1, 1'b0, 25);

    $display("Summary: %0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  // Hang guard
  initial begin
    #(WatchdogNs);
    $display("Timeout after %0d ns, the tests did not complete", WatchdogNs);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/armCtrl_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "armCtrl_config.svh"

module armCtrlAssert (
  input logic                   clk,
  input logic                   rstN,
  input logic [3:0]             aluOpE,
  input logic                   aluSrcE,
  input logic                   branchTakenE,
  input logic                   memWriteM,
  input logic                   memtoRegM,
  input logic                   regWriteM,
  input logic [`ARM_MASK_W-1:0] byteMaskM,
  input logic                   regWriteW,
  input logic                   memtoRegW,
  input logic                   pcSrcW,
  input logic [`ARM_FLAG_W-1:0] cpsrFlags
);

  // A Memory slot is a load or a store, never both
  loadStoreExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(memWriteM && memtoRegM))
    else $error("memWriteM and memtoRegM both high");

  // Whole word or a single lane
  storeMaskShape: assert property (@(posedge clk) disable iff (!rstN)
    memWriteM |-> (byteMaskM == '1 || $onehot(byteMaskM)))
    else $error("byteMaskM %b is neither a word nor one lane", byteMaskM);

  // First clock out of reset sees only bubbles
  quietAfterReset: assert property (@(posedge clk)
    $rose(rstN) |-> (aluOpE == 4'h0 && !aluSrcE && !branchTakenE && !memWriteM
      && !memtoRegM && !regWriteM && byteMaskM == '0 && !regWriteW
      && !memtoRegW && !pcSrcW && cpsrFlags == '0))
    else $error("control output nonzero right after reset");

endmodule

bind armCtrlTop armCtrlAssert uAssert (
  .clk          (clk),
  .rstN         (rstN),
  .aluOpE       (aluOpE),
  .aluSrcE      (aluSrcE),
  .branchTakenE (branchTakenE),
  .memWriteM    (memWriteM),
  .memtoRegM    (memtoRegM),
  .regWriteM    (regWriteM),
  .byteMaskM    (byteMaskM),
  .regWriteW    (regWriteW),
  .memtoRegW    (memtoRegW),
  .pcSrcW       (pcSrcW),
  .cpsrFlags    (cpsrFlags)
);

`default_nettype wire
